// File: axi4_monitor_consts.svh
`ifndef AXI4_MONITOR_CONSTS_SVH
`define AXI4_MONITOR_CONSTS_SVH

//--------------------------------------------------------------------------
// aw channel geometry
//--------------------------------------------------------------------------

// byte address width of the aw channel
`define AXI_ADDR_W 32

// data bus width in bytes
`define AXI_DATA_BYTES 8

// largest legal awsize code, log2 of the bus bytes
`define AXI_MAX_SIZE ($clog2(`AXI_DATA_BYTES))

//--------------------------------------------------------------------------
// monitor reporting
//--------------------------------------------------------------------------

// number of distinct error kinds
`define MON_ERR_KINDS 6

// error counter width, saturates at all ones
`define MON_CNT_W 8

`endif

// File: axi4_types_pkg.sv
`include "axi4_monitor_consts.svh"

package axi4_types_pkg;

  //------------------------------------------------------------------------
  // aw payload fields
  //------------------------------------------------------------------------

  // byte address
  typedef logic [`AXI_ADDR_W-1:0] axi_addr_t;

  // transaction id
  typedef logic [3:0] axi_id_t;

  // beats minus one
  typedef logic [3:0] axi_len_t;

  // log2 of bytes per beat
  typedef logic [2:0] axi_size_t;

  // burst type, encoding as on the bus
  typedef enum logic [1:0] {
    FIXED    = 2'b00,
    INCR     = 2'b01,
    WRAP     = 2'b10,
    RESERVED = 2'b11
  } axi_burst_e;

endpackage

// File: monitor_pkg.sv
`include "axi4_monitor_consts.svh"

package monitor_pkg;

  //------------------------------------------------------------------------
  // error reporting types
  //------------------------------------------------------------------------

  // error kinds, value doubles as bit index into the flag vector
  // lower value wins when several hit in one cycle
  typedef enum logic [2:0] {
    // stability checker
    ERR_PAYLOAD_CHANGED = 3'd0,
    ERR_VALID_DROPPED   = 3'd1,
    // encoding checker
    ERR_BURST_RESERVED  = 3'd2,
    ERR_SIZE_TOO_BIG    = 3'd3,
    ERR_WRAP_ILLEGAL    = 3'd4,
    ERR_4K_CROSS        = 3'd5
  } mon_err_e;

  // one bit per kind
  typedef logic [`MON_ERR_KINDS-1:0] mon_flags_t;

  // violating cycle count
  typedef logic [`MON_CNT_W-1:0] mon_cnt_t;

endpackage

// File: aw_stability_checker.sv
`timescale 1ns/1ns

module aw_stability_checker (
  input  logic                       aclk,
  input  logic                       rst_n,
  input  axi4_types_pkg::axi_id_t    awid,
  input  axi4_types_pkg::axi_addr_t  awaddr,
  input  axi4_types_pkg::axi_len_t   awlen,
  input  axi4_types_pkg::axi_size_t  awsize,
  input  axi4_types_pkg::axi_burst_e awburst,
  input  logic                       awvalid,
  input  logic                       awready,
  output logic [1:0]                 stab_err
);
  import axi4_types_pkg::*;

  // copy of the payload seen at the previous edge
  axi_id_t    id_q;
  axi_addr_t  addr_q;
  axi_len_t   len_q;
  axi_size_t  size_q;
  axi_burst_e burst_q;

  // valid without ready at the previous edge
  logic stalled_q;
  // handshake at the previous edge
  logic hs_q;

  logic payload_changed;
  logic valid_dropped;

  //--------------------------------------------------------------------------
  // compare against the stalled copy
  //--------------------------------------------------------------------------

  // any field moved while the master was waiting
  assign payload_changed = stalled_q &&
                           ((awid    != id_q)   ||
                            (awaddr  != addr_q) ||
                            (awlen   != len_q)  ||
                            (awsize  != size_q) ||
                            (awburst != burst_q));

  // master withdrew the request before ready
  assign valid_dropped = stalled_q && !awvalid;

  // payload snapshot every cycle, only read while stalled
  always_ff @(posedge aclk) begin
    id_q    <= awid;
    addr_q  <= awaddr;
    len_q   <= awlen;
    size_q  <= awsize;
    burst_q <= awburst;
  end

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      stalled_q <= 1'b0;
      hs_q      <= 1'b0;
      stab_err  <= 2'b00;
    end else begin
      stalled_q <= awvalid && !awready;
      hs_q      <= awvalid && awready;
      // bit 0 payload changed, bit 1 valid dropped
      stab_err  <= {valid_dropped, payload_changed};
    end
  end

  //--------------------------------------------------------------------------
  // checks
  //--------------------------------------------------------------------------

  // a drop strobe and a completed transfer are exclusive in the same cycle
  a_drop_not_handshake: assert property (
    @(posedge aclk) disable iff (!rst_n)
    stab_err[1] |-> !hs_q
  );

endmodule

// File: aw_encoding_checker.sv
`timescale 1ns/1ns

`include "axi4_monitor_consts.svh"

module aw_encoding_checker (
  input  logic                       aclk,
  input  logic                       rst_n,
  input  axi4_types_pkg::axi_addr_t  awaddr,
  input  axi4_types_pkg::axi_len_t   awlen,
  input  axi4_types_pkg::axi_size_t  awsize,
  input  axi4_types_pkg::axi_burst_e awburst,
  input  logic                       awvalid,
  input  logic                       awready,
  output logic [3:0]                 enc_err
);
  import axi4_types_pkg::*;

  // size code limit in the field's own width
  localparam axi_size_t MAX_SIZE = axi_size_t'(`AXI_MAX_SIZE);

  logic        handshake;
  logic        burst_reserved;
  logic        size_too_big;
  logic        wrap_len_ok;
  logic        wrap_illegal;
  logic        crosses_4k;
  // low address bits below one beat
  logic [11:0] addr_mask;
  // 16 beats of 128 bytes still fit in 13 bits
  logic [12:0] beat_cnt;
  logic [12:0] byte_len;
  logic [12:0] last_offset;

  assign handshake = awvalid && awready;

  //--------------------------------------------------------------------------
  // burst decode
  //--------------------------------------------------------------------------

  assign burst_reserved = (awburst == RESERVED);

  // beat wider than the data bus
  assign size_too_big = (awsize > MAX_SIZE);

  assign addr_mask = (12'd1 << awsize) - 12'd1;

  // wrap needs 2, 4, 8 or 16 beats
  assign wrap_len_ok = (awlen == 4'd1) || (awlen == 4'd3) ||
                       (awlen == 4'd7) || (awlen == 4'd15);

  // and a start address aligned to the beat size
  assign wrap_illegal = (awburst == WRAP) &&
                        (!wrap_len_ok || ((awaddr[11:0] & addr_mask) != 12'd0));

  // total burst bytes
  assign beat_cnt = {9'd0, awlen} + 13'd1;
  assign byte_len = beat_cnt << awsize;

  // last byte offset inside the 4k page, from the aligned start
  assign last_offset = {1'b0, awaddr[11:0] & ~addr_mask} + byte_len - 13'd1;

  // carry into bit 12 means the burst leaves its page
  assign crosses_4k = (awburst == INCR) && last_offset[12];

  // strobes only on a handshake, several may fire together
  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      enc_err <= 4'd0;
    end else if (handshake) begin
      enc_err <= {crosses_4k, wrap_illegal, size_too_big, burst_reserved};
    end else begin
      enc_err <= 4'd0;
    end
  end

  //--------------------------------------------------------------------------
  // checks
  //--------------------------------------------------------------------------

  // no strobe without a handshake one edge earlier
  a_enc_only_after_hs: assert property (
    @(posedge aclk) disable iff (!rst_n)
    !handshake |=> (enc_err == 4'd0)
  );

endmodule

// File: aw_error_collector.sv
`timescale 1ns/1ns

module aw_error_collector (
  input  logic                    aclk,
  input  logic                    rst_n,
  input  logic [1:0]              stab_err,
  input  logic [3:0]              enc_err,
  output logic                    err_valid,
  output monitor_pkg::mon_err_e   err_code,
  output monitor_pkg::mon_flags_t err_flags,
  output monitor_pkg::mon_cnt_t   err_count
);
  import monitor_pkg::*;

  // saturation point of the counter
  localparam mon_cnt_t CNT_MAX = '1;

  // kind vector, bit index equals the kind code
  mon_flags_t kinds;
  logic       any_err;
  mon_err_e   first_kind;

  //--------------------------------------------------------------------------
  // merge and prioritise
  //--------------------------------------------------------------------------

  // stability kinds 0..1 below encoding kinds 2..5
  assign kinds   = {enc_err, stab_err};
  assign any_err = |kinds;

  // lowest set kind wins, scan downwards so the last hit is kept
  always_comb begin
    first_kind = ERR_PAYLOAD_CHANGED;
    for (int i = $bits(mon_flags_t) - 1; i >= 0; i--) begin
      if (kinds[i]) begin
        first_kind = mon_err_e'(i[2:0]);
      end
    end
  end

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      err_valid <= 1'b0;
      err_flags <= '0;
      err_count <= '0;
    end else begin
      // one pulse per violating cycle
      err_valid <= any_err;
      // sticky until reset
      err_flags <= err_flags | kinds;
      if (any_err && (err_count != CNT_MAX)) begin
        err_count <= err_count + 1'b1;
      end
    end
  end

  // code only meaningful alongside err_valid
  always_ff @(posedge aclk) begin
    if (any_err) begin
      err_code <= first_kind;
    end
  end

  //--------------------------------------------------------------------------
  // checks
  //--------------------------------------------------------------------------

  // count only climbs or holds at the limit
  a_count_monotonic: assert property (
    @(posedge aclk) disable iff (!rst_n)
    err_count >= $past(err_count)
  );

endmodule

// File: aw_protocol_monitor.sv
`timescale 1ns/1ns

module aw_protocol_monitor (
  input  logic                       aclk,
  input  logic                       rst_n,
  input  axi4_types_pkg::axi_id_t    awid,
  input  axi4_types_pkg::axi_addr_t  awaddr,
  input  axi4_types_pkg::axi_len_t   awlen,
  input  axi4_types_pkg::axi_size_t  awsize,
  input  axi4_types_pkg::axi_burst_e awburst,
  input  logic                       awvalid,
  input  logic                       awready,
  output logic                       err_valid,
  output monitor_pkg::mon_err_e      err_code,
  output monitor_pkg::mon_flags_t    err_flags,
  output monitor_pkg::mon_cnt_t      err_count
);

  // checker strobes, both one register deep
  logic [1:0] stab_err;
  logic [3:0] enc_err;

  //--------------------------------------------------------------------------
  // checkers
  //--------------------------------------------------------------------------

  // stall rules, payload and valid held until ready
  aw_stability_checker u_stab (
    .aclk     (aclk),
    .rst_n    (rst_n),
    .awid     (awid),
    .awaddr   (awaddr),
    .awlen    (awlen),
    .awsize   (awsize),
    .awburst  (awburst),
    .awvalid  (awvalid),
    .awready  (awready),
    .stab_err (stab_err)
  );

  // burst attribute rules at the handshake
  aw_encoding_checker u_enc (
    .aclk    (aclk),
    .rst_n   (rst_n),
    .awaddr  (awaddr),
    .awlen   (awlen),
    .awsize  (awsize),
    .awburst (awburst),
    .awvalid (awvalid),
    .awready (awready),
    .enc_err (enc_err)
  );

  // sticky flags, strobe, code and count
  aw_error_collector u_coll (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .stab_err  (stab_err),
    .enc_err   (enc_err),
    .err_valid (err_valid),
    .err_code  (err_code),
    .err_flags (err_flags),
    .err_count (err_count)
  );

endmodule

// File: tb_aw_protocol_monitor.sv
`timescale 1ns/1ns

`include "axi4_monitor_consts.svh"

module tb_aw_protocol_monitor;
  import axi4_types_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int RAND_TXNS  = 300;
  localparam int SAT_CYCLES = 300;
  // reset, at most five cycles per random transfer, the saturation run and slack
  localparam int WATCHDOG_CYCLES = 16 + 100 + RAND_TXNS * 5 + SAT_CYCLES + 500;

  logic                    aclk;
  logic                    rst_n;
  axi_id_t                 awid;
  axi_addr_t               awaddr;
  axi_len_t                awlen;
  axi_size_t               awsize;
  axi_burst_e              awburst;
  logic                    awvalid;
  logic                    awready;
  logic                    err_valid;
  monitor_pkg::mon_err_e   err_code;
  monitor_pkg::mon_flags_t err_flags;
  monitor_pkg::mon_cnt_t   err_count;

  int errors    = 0;
  int errs_seen = 0;
  int tests     = 0;

  aw_protocol_monitor dut0 (.*);

  //--------------------------------------------------------------------------
  // reference model
  //--------------------------------------------------------------------------

  // bus payload as seen at the previous edge
  logic [`AXI_ADDR_W+12:0]   payload_m;
  logic                      stalled_m;
  logic [`MON_ERR_KINDS-1:0] kind_now;
  logic [`MON_ERR_KINDS-1:0] kind_d1;
  logic [`MON_ERR_KINDS-1:0] kind_d2;
  logic [`MON_ERR_KINDS-1:0] flags_m;
  logic [`MON_CNT_W-1:0]     count_m;
  // one extra bit keeps the carry out of the top page
  logic [`AXI_ADDR_W:0]      beat_bytes;
  logic [`AXI_ADDR_W:0]      start_m;
  logic [`AXI_ADDR_W:0]      last_m;

  always_comb begin
    beat_bytes  = 33'd1 << awsize;
    start_m     = {1'b0, awaddr} & ~(beat_bytes - 33'd1);
    last_m      = start_m + ({29'd0, awlen} + 33'd1) * beat_bytes - 33'd1;
    kind_now    = '0;
    // stall rules
    kind_now[0] = stalled_m && ({awid, awaddr, awlen, awsize, awburst} != payload_m);
    kind_now[1] = stalled_m && !awvalid;
    if (awvalid && awready) begin
      kind_now[2] = (awburst == RESERVED);
      kind_now[3] = (awsize > 3'(`AXI_MAX_SIZE));
      // wrap of 2, 4, 8 or 16 beats from a beat boundary
      kind_now[4] = (awburst == WRAP) &&
                    (!(awlen inside {4'd1, 4'd3, 4'd7, 4'd15}) ||
                     ((awaddr[11:0] & (beat_bytes[11:0] - 12'd1)) != 12'd0));
      // last byte lands in another 4k page
      kind_now[5] = (awburst == INCR) && (last_m[`AXI_ADDR_W:12] != start_m[`AXI_ADDR_W:12]);
    end
  end

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      payload_m <= '0;
      stalled_m <= 1'b0;
      kind_d1   <= '0;
      kind_d2   <= '0;
      flags_m   <= '0;
      count_m   <= '0;
    end else begin
      payload_m <= {awid, awaddr, awlen, awsize, awburst};
      stalled_m <= awvalid && !awready;
      // checker stage then collector stage
      kind_d1   <= kind_now;
      kind_d2   <= kind_d1;
      flags_m   <= flags_m | kind_d1;
      if ((|kind_d1) && (count_m != '1)) begin
        count_m <= count_m + 1'b1;
      end
    end
  end

  // lowest set kind is the reported one
  function automatic logic [2:0] lowest_kind(input logic [`MON_ERR_KINDS-1:0] k);
    for (int i = 0; i < `MON_ERR_KINDS; i++) begin
      if (k[i]) return 3'(i);
    end
    return 3'd0;
  endfunction

  function automatic void flag_mismatch(input string sig, input logic [31:0] got,
                                        input logic [31:0] exp);
    $display("MISMATCH %s got %h expected %h", sig, got, exp);
    errors = errors + 1;
  endfunction

  // outputs against the model, every edge out of reset
  a_valid: assert property (@(posedge aclk) disable iff (!rst_n) err_valid == (|kind_d2))
    else flag_mismatch("err_valid", 32'($sampled(err_valid)), 32'($sampled(|kind_d2)));
  a_code: assert property (@(posedge aclk) disable iff (!rst_n)
    err_valid |-> (err_code == lowest_kind(kind_d2)))
    else flag_mismatch("err_code", 32'($sampled(err_code)), 32'(lowest_kind($sampled(kind_d2))));
  a_flags: assert property (@(posedge aclk) disable iff (!rst_n) err_flags == flags_m)
    else flag_mismatch("err_flags", 32'($sampled(err_flags)), 32'($sampled(flags_m)));
  a_count: assert property (@(posedge aclk) disable iff (!rst_n) err_count == count_m)
    else flag_mismatch("err_count", 32'($sampled(err_count)), 32'($sampled(count_m)));

  //--------------------------------------------------------------------------
  // clock, watchdog and stimulus
  //--------------------------------------------------------------------------

  initial begin
    aclk = 1'b0;
    forever #(CLK_PERIOD / 2) aclk = ~aclk;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired before all tests finished");
    $display("Errors found");
    $finish;
  end

  // one aw transfer, ready after the stall cycles
  // glitch 1 moves the address and glitch 2 drops awvalid on the first stall cycle
  task automatic send_aw(input axi_id_t id, input axi_addr_t addr, input axi_len_t len,
                         input axi_size_t size, input axi_burst_e burst, input int stall,
                         input int glitch);
    @(negedge aclk);
    awid    = id;
    awaddr  = addr;
    awlen   = len;
    awsize  = size;
    awburst = burst;
    awvalid = 1'b1;
    awready = (stall == 0);
    for (int i = 0; i < stall; i++) begin
      @(negedge aclk);
      if (i == 0 && glitch == 1) awaddr = awaddr ^ 32'h40;
      if (i == 0 && glitch == 2) awvalid = 1'b0;
      awready = awvalid && (i == stall - 1);
    end
    @(negedge aclk);
    awvalid = 1'b0;
    awready = 1'b0;
  endtask

  task automatic report_test(input string name);
    // drain both pipeline stages first
    repeat (4) @(negedge aclk);
    tests = tests + 1;
    if (errors == errs_seen) begin
      $display("test %0d %s: pass", tests, name);
    end else begin
      $display("test %0d %s: FAIL with %0d errors", tests, name, errors - errs_seen);
    end
    errs_seen = errors;
  endtask

  initial begin
    axi_addr_t addr;
    int        glitch;
    void'($urandom(32'h2dfca747));
    rst_n   = 1'b0;
    awvalid = 1'b0;
    awready = 1'b0;
    awid    = '0;
    awaddr  = '0;
    awlen   = '0;
    awsize  = '0;
    awburst = FIXED;
    repeat (16) @(posedge aclk);
    @(negedge aclk);
    rst_n = 1'b1;

    send_aw(4'd1, 32'h0000_1000, 4'd3, 3'd2, INCR, 3, 0);
    report_test("clean stall after reset");
    send_aw(4'd2, 32'h0000_2000, 4'd1, 3'd2, INCR, 2, 1);
    report_test("payload change in stall");
    send_aw(4'd3, 32'h0000_3000, 4'd0, 3'd2, INCR, 2, 2);
    report_test("awvalid dropped in stall");

    send_aw(4'd4, 32'h0000_4000, 4'd0, 3'd2, RESERVED, 0, 0);
    send_aw(4'd5, 32'h0000_5000, 4'd0, 3'd4, INCR, 1, 0);
    send_aw(4'd6, 32'h0000_6000, 4'd4, 3'd2, WRAP, 0, 0);
    send_aw(4'd7, 32'h0000_7ff8, 4'd3, 3'd3, INCR, 0, 0);
    // oversized beat on a 5 beat wrap
    send_aw(4'd8, 32'h0000_8000, 4'd4, 3'd4, WRAP, 0, 0);
    report_test("illegal encodings");

    for (int n = 0; n < RAND_TXNS; n++) begin
      addr = $urandom;
      // half of them near a page end
      if ($urandom_range(0, 1) == 1) addr[11:5] = 7'h7f;
      glitch = ($urandom_range(0, 9) < 8) ? 0 : int'($urandom_range(1, 2));
      send_aw(axi_id_t'($urandom), addr, axi_len_t'($urandom), axi_size_t'($urandom_range(0, 4)),
              axi_burst_e'($urandom_range(0, 3)), int'($urandom_range(0, 3)), glitch);
    end
    report_test("random transfers");

    // back to back reserved bursts
    @(negedge aclk);
    awburst = RESERVED;
    awvalid = 1'b1;
    awready = 1'b1;
    repeat (SAT_CYCLES) @(negedge aclk);
    awvalid = 1'b0;
    awready = 1'b0;
    report_test("counter saturation");

    $display("tests %0d, errors %0d", tests, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+.
axi4_types_pkg.sv
monitor_pkg.sv
aw_stability_checker.sv
aw_encoding_checker.sv
aw_error_collector.sv
aw_protocol_monitor.sv
tb_aw_protocol_monitor.sv

// File: run_sim.sh
#!/bin/sh
# build the aw monitor testbench with verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_aw_protocol_monitor \
  -f sources.f \
  -o tb_aw_protocol_monitor

./obj_dir/tb_aw_protocol_monitor > sim.log
cat sim.log

if grep -q "Errors found" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
